// File: aznable_consts.svh
`ifndef AZNABLE_CONSTS_SVH
`define AZNABLE_CONSTS_SVH

// starfield layer count
`define AZ_NUM_LAYERS 3

// 24 MHz cycles in one millisecond
`define AZ_MS_DIVIDER 24000

// upper address byte of each memory mapped region
`define AZ_REGION_JOY 8'h81
`define AZ_REGION_PADDLE 8'h84
`define AZ_REGION_TIMER 8'h89
`define AZ_REGION_STARS 8'h8A

// layer 0 runs the full 22-bit register
`define AZ_SEED0 22'h1FFFFF
`define AZ_TAPS0 22'b1100000000000000000000

// layers 1 and 2 only use the low 21 bits
`define AZ_SEED1 22'h1FFFF0
`define AZ_TAPS1 22'b0101010000000000000000
`define AZ_SEED2 22'h1FFF00
`define AZ_TAPS2 22'b0101000000000000000000

// these lfsr bits all set means a star
`define AZ_STAR_MASK 22'b0000111100001111000011

// layer control byte fields
`define AZ_CFG_ENABLE_BIT 0

`endif

// File: aznable_pkg.sv
package aznable_pkg;

	// bus data, also one pixel
	typedef logic [7:0] byte_t;

	// cpu style 16-bit address
	typedef logic [15:0] addr_t;

	// wrapping millisecond count
	typedef logic [15:0] ms_count_t;

	// starfield shift register
	typedef logic [21:0] lfsr_t;

	// six joysticks, 32 buttons each
	typedef logic [191:0] joy_bus_t;

	// six paddles, 0..255
	typedef logic [47:0] paddle_bus_t;

	// four-phase handshake slave
	typedef enum logic {
		IDLE,
		ACKED
	} bus_state_t;

	// region from the upper address byte
	typedef enum logic [2:0] {
		JOY,
		PADDLE,
		TIMER,
		STARS,
		NONE
	} region_t;

endpackage

// File: star_lane_if.sv
`timescale 1ns/1ps

interface star_lane_if;

	// control byte write, one cycle strobe
	logic cfg_wr;
	aznable_pkg::byte_t cfg_data;

	// registered star of this layer
	logic star_on;
	aznable_pkg::byte_t star_colour;

	// bus side
	modport feed (
		output cfg_wr,
		output cfg_data
	);

	// the lfsr layer itself
	modport layer (
		input cfg_wr,
		input cfg_data,
		output star_on,
		output star_colour
	);

	// mixer side
	modport drain (
		input star_on,
		input star_colour
	);

endinterface

// File: bus_decoder.sv
`timescale 1ns/1ps
`include "aznable_consts.svh"

module bus_decoder (
	input logic clk_24,
	input logic arst_n,
	input logic bus_req,
	input logic bus_we,
	input aznable_pkg::addr_t bus_addr,
	input aznable_pkg::byte_t bus_wdata,
	output logic bus_ack,
	output aznable_pkg::byte_t bus_rdata,
	input aznable_pkg::joy_bus_t joystick,
	input aznable_pkg::paddle_bus_t paddle,
	input aznable_pkg::ms_count_t ms_count,
	output logic timer_clear,
	star_lane_if.feed lanes [`AZ_NUM_LAYERS]
);

	aznable_pkg::bus_state_t state;
	aznable_pkg::region_t region;
	aznable_pkg::byte_t read_byte;
	aznable_pkg::byte_t cfg_data_q;
	logic [`AZ_NUM_LAYERS-1:0] cfg_wr_q;
	logic [4:0] joy_sel;
	logic [2:0] paddle_sel;
	logic [1:0] layer_sel;
	logic start;

	assign joy_sel = bus_addr[4:0];
	assign paddle_sel = bus_addr[2:0];
	assign layer_sel = bus_addr[2:1];

	// new transfer seen while idle
	assign start = (state == aznable_pkg::IDLE) && bus_req;
	assign bus_ack = (state == aznable_pkg::ACKED);

	// region decode on the high byte
	always_comb begin
		case (bus_addr[15:8])
			`AZ_REGION_JOY: region = aznable_pkg::JOY;
			`AZ_REGION_PADDLE: region = aznable_pkg::PADDLE;
			`AZ_REGION_TIMER: region = aznable_pkg::TIMER;
			`AZ_REGION_STARS: region = aznable_pkg::STARS;
			default: region = aznable_pkg::NONE;
		endcase
	end

	// read data mux
	always_comb begin
		read_byte = '0;
		case (region)
			aznable_pkg::JOY: begin
				// 24 joystick bytes, rest reads 0
				if (joy_sel <= 5'd23) begin
					read_byte = joystick[{joy_sel, 3'b000} +: 8];
				end
			end
			aznable_pkg::PADDLE: begin
				// only six paddles
				if (paddle_sel <= 3'd5) begin
					read_byte = paddle[{paddle_sel, 3'b000} +: 8];
				end
			end
			aznable_pkg::TIMER: begin
				read_byte = ms_count[{bus_addr[0], 3'b000} +: 8];
			end
			default: begin
				read_byte = '0;
			end
		endcase
	end

	// handshake fsm
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			state <= aznable_pkg::IDLE;
			bus_rdata <= '0;
		end else begin
			case (state)
				aznable_pkg::IDLE: begin
					if (bus_req) begin
						state <= aznable_pkg::ACKED;
						// held until the next transfer
						bus_rdata <= read_byte;
					end
				end
				aznable_pkg::ACKED: begin
					// master has released req
					if (!bus_req) begin
						state <= aznable_pkg::IDLE;
					end
				end
				default: begin
					state <= aznable_pkg::IDLE;
				end
			endcase
		end
	end

	// write strobes, one cycle at the ack edge
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			timer_clear <= 1'b0;
			cfg_wr_q <= '0;
		end else begin
			timer_clear <= start && bus_we && (region == aznable_pkg::TIMER);
			for (int i = 0; i < `AZ_NUM_LAYERS; i++) begin
				// select 3 matches no layer
				cfg_wr_q[i] <= start && bus_we && (region == aznable_pkg::STARS)
					&& (layer_sel == i[1:0]);
			end
		end
	end

	// write data for the layers
	always_ff @(posedge clk_24) begin
		if (start && bus_we) begin
			cfg_data_q <= bus_wdata;
		end
	end

	for (genvar g = 0; g < `AZ_NUM_LAYERS; g++) begin : g_lane
		assign lanes[g].cfg_wr = cfg_wr_q[g];
		assign lanes[g].cfg_data = cfg_data_q;
	end

endmodule

// File: ms_timer.sv
`timescale 1ns/1ps
`include "aznable_consts.svh"

module ms_timer (
	input logic clk_24,
	input logic arst_n,
	input logic clear,
	output aznable_pkg::ms_count_t ms_count
);

	localparam int PRE_W = $clog2(`AZ_MS_DIVIDER);

	// cycles into the current millisecond
	logic [PRE_W-1:0] prescale;
	logic ms_tick;

	assign ms_tick = (prescale == PRE_W'(`AZ_MS_DIVIDER - 1));

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			prescale <= '0;
			ms_count <= '0;
		end else if (clear) begin
			// restart the millisecond too
			prescale <= '0;
			ms_count <= '0;
		end else if (ms_tick) begin
			prescale <= '0;
			// wraps after 65535
			ms_count <= ms_count + 1'b1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

// File: starfield_layer.sv
`timescale 1ns/1ps
`include "aznable_consts.svh"

module starfield_layer #(
	parameter aznable_pkg::lfsr_t SEED = `AZ_SEED0,
	parameter aznable_pkg::lfsr_t TAPS = `AZ_TAPS0
) (
	input logic clk_24,
	input logic arst_n,
	input logic ce_6,
	input logic vblank,
	star_lane_if.layer lane
);

	aznable_pkg::byte_t cfg;
	aznable_pkg::lfsr_t lfsr;
	logic feedback;
	logic star_hit;

	// fibonacci feedback from the tap set
	assign feedback = ^(lfsr & TAPS);

	// enabled and all mask bits set
	assign star_hit = cfg[`AZ_CFG_ENABLE_BIT]
		&& ((lfsr & `AZ_STAR_MASK) == `AZ_STAR_MASK);

	// control byte from the bus
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			cfg <= '0;
		end else if (lane.cfg_wr) begin
			cfg <= lane.cfg_data;
		end
	end

	// same star pattern every frame
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= SEED;
		end else if (vblank) begin
			lfsr <= SEED;
		end else if (ce_6) begin
			// shift right, feedback into the top bit
			lfsr <= {feedback, lfsr[21:1]};
		end
	end

	// star output, one pixel per step
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			lane.star_on <= 1'b0;
			lane.star_colour <= '0;
		end else if (ce_6) begin
			lane.star_on <= star_hit;
			// low byte gives the brightness
			lane.star_colour <= star_hit ? lfsr[7:0] : '0;
		end
	end

endmodule

// File: star_mixer.sv
`timescale 1ns/1ps
`include "aznable_consts.svh"

module star_mixer (
	input logic clk_24,
	input logic arst_n,
	star_lane_if.drain lanes [`AZ_NUM_LAYERS],
	output aznable_pkg::byte_t pixel,
	output logic pixel_on
);

	logic [`AZ_NUM_LAYERS-1:0] on_vec;
	aznable_pkg::byte_t colour [`AZ_NUM_LAYERS];
	aznable_pkg::byte_t pick;

	// flatten the lanes
	for (genvar g = 0; g < `AZ_NUM_LAYERS; g++) begin : g_tap
		assign on_vec[g] = lanes[g].star_on;
		assign colour[g] = lanes[g].star_colour;
	end

	// scan from the back so layer 0 wins
	always_comb begin
		pick = '0;
		for (int i = `AZ_NUM_LAYERS - 1; i >= 0; i--) begin
			if (on_vec[i]) begin
				// deeper layers lose one more top bit each
				pick = colour[i] & aznable_pkg::byte_t'(8'hFF >> i);
			end
		end
	end

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			pixel <= '0;
			pixel_on <= 1'b0;
		end else begin
			pixel <= pick;
			pixel_on <= |on_vec;
		end
	end

endmodule

// File: aznable_io_top.sv
`timescale 1ns/1ps
`include "aznable_consts.svh"

module aznable_io_top (
	input logic clk_24,
	input logic arst_n,
	input logic ce_6,
	input logic vblank,
	input logic bus_req,
	input logic bus_we,
	input aznable_pkg::addr_t bus_addr,
	input aznable_pkg::byte_t bus_wdata,
	input aznable_pkg::joy_bus_t joystick,
	input aznable_pkg::paddle_bus_t paddle,
	output logic bus_ack,
	output aznable_pkg::byte_t bus_rdata,
	output aznable_pkg::byte_t pixel,
	output logic pixel_on
);

	// per layer lfsr setup
	localparam aznable_pkg::lfsr_t layer_seed [`AZ_NUM_LAYERS] = '{
		`AZ_SEED0, `AZ_SEED1, `AZ_SEED2
	};
	localparam aznable_pkg::lfsr_t layer_taps [`AZ_NUM_LAYERS] = '{
		`AZ_TAPS0, `AZ_TAPS1, `AZ_TAPS2
	};

	aznable_pkg::ms_count_t ms_count;
	logic timer_clear;

	// one lane per starfield layer
	star_lane_if lanes [`AZ_NUM_LAYERS] ();

	bus_decoder u_bus_decoder (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.bus_req(bus_req),
		.bus_we(bus_we),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_ack(bus_ack),
		.bus_rdata(bus_rdata),
		.joystick(joystick),
		.paddle(paddle),
		.ms_count(ms_count),
		.timer_clear(timer_clear),
		.lanes(lanes)
	);

	ms_timer u_ms_timer (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.clear(timer_clear),
		.ms_count(ms_count)
	);

	for (genvar g = 0; g < `AZ_NUM_LAYERS; g++) begin : g_layer
		starfield_layer #(
			.SEED(layer_seed[g]),
			.TAPS(layer_taps[g])
		) u_layer (
			.clk_24(clk_24),
			.arst_n(arst_n),
			.ce_6(ce_6),
			.vblank(vblank),
			.lane(lanes[g])
		);
	end

	// grey star pixel
	star_mixer u_star_mixer (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.lanes(lanes),
		.pixel(pixel),
		.pixel_on(pixel_on)
	);

endmodule

// File: aznable_io_sva.sv
`timescale 1ns/1ps
`include "aznable_consts.svh"

module aznable_io_sva (
	input logic clk_24,
	input logic arst_n,
	input logic bus_req,
	input logic bus_we,
	input aznable_pkg::addr_t bus_addr,
	input aznable_pkg::byte_t bus_wdata,
	input logic bus_ack,
	input aznable_pkg::byte_t bus_rdata,
	input aznable_pkg::byte_t pixel,
	input logic pixel_on
);

	int failures = 0;
	// enable bits as written over the bus
	logic [`AZ_NUM_LAYERS-1:0] layer_en;
	// cycles since the last layer write
	logic [3:0] settle;
	logic star_write;
	logic settled;
	logic [1:0] sel;

	assign sel = bus_addr[2:1];
	assign star_write = bus_req && !bus_ack && bus_we && (bus_addr[15:8] == `AZ_REGION_STARS);
	// strobe, control register, star register and mixer all done by then
	assign settled = settle >= 4'd8;

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			layer_en <= '0;
			settle <= 4'd15;
		end else if (star_write) begin
			if (sel != 2'd3) begin
				layer_en[sel] <= bus_wdata[`AZ_CFG_ENABLE_BIT];
			end
			settle <= '0;
		end else if (settle != 4'd15) begin
			settle <= settle + 1'b1;
		end
	end

	ack_rise: assert property (@(posedge clk_24) disable iff (!arst_n)
		$rose(bus_ack) |-> $past(bus_req))
		else begin
			failures++;
			$error("bus_ack rose while bus_req was low");
		end

	ack_fall: assert property (@(posedge clk_24) disable iff (!arst_n)
		$fell(bus_ack) |-> !$past(bus_req))
		else begin
			failures++;
			$error("bus_ack fell while bus_req was high");
		end

	rdata_hold: assert property (@(posedge clk_24) disable iff (!arst_n)
		bus_ack && $past(bus_ack) |-> $stable(bus_rdata))
		else begin
			failures++;
			$error("bus_rdata changed while bus_ack was high");
		end

	// nothing enabled means a dark pixel
	dark_sky: assert property (@(posedge clk_24) disable iff (!arst_n)
		settled && layer_en == '0 |-> !pixel_on && pixel == 8'h00)
		else begin
			failures++;
			$error("pixel lit with every layer disabled");
		end

	layer2_depth: assert property (@(posedge clk_24) disable iff (!arst_n)
		settled && layer_en == 3'b100 && pixel_on |-> pixel[7:6] == 2'b00)
		else begin
			failures++;
			$error("layer 2 pixel has bits 7:6 set");
		end

	layer1_depth: assert property (@(posedge clk_24) disable iff (!arst_n)
		settled && layer_en == 3'b010 && pixel_on |-> !pixel[7])
		else begin
			failures++;
			$error("layer 1 pixel has bit 7 set");
		end

endmodule

bind aznable_io_top aznable_io_sva u_sva (
	.clk_24(clk_24),
	.arst_n(arst_n),
	.bus_req(bus_req),
	.bus_we(bus_we),
	.bus_addr(bus_addr),
	.bus_wdata(bus_wdata),
	.bus_ack(bus_ack),
	.bus_rdata(bus_rdata),
	.pixel(pixel),
	.pixel_on(pixel_on)
);

// File: tb_aznable_io.sv
`timescale 1ns/1ps
`include "aznable_consts.svh"

module tb_aznable_io;

	// 2 x 24000 timer wait, 2000 dark, 2 x 6000 star phases, bus traffic
	localparam int TIMEOUT_CYCLES = 80000;
	localparam int PHASE_CYCLES = 6000;
	localparam int DARK_CYCLES = 2000;
	localparam int RANDOM_READS = 60;

	logic clk_24;
	logic arst_n;
	logic ce_6 = 1'b0;
	logic vblank = 1'b0;
	logic bus_req;
	logic bus_we;
	aznable_pkg::addr_t bus_addr;
	aznable_pkg::byte_t bus_wdata;
	aznable_pkg::joy_bus_t joystick;
	aznable_pkg::paddle_bus_t paddle;
	logic bus_ack;
	aznable_pkg::byte_t bus_rdata;
	aznable_pkg::byte_t pixel;
	logic pixel_on;

	int seed = 32'h91769c8e;
	int cycles = 0;
	// position within a 400 cycle video line
	int line_pos = 0;

	aznable_io_top UUT (.*);

	initial begin
		clk_24 = 1'b0;
		forever #2 clk_24 = ~clk_24;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// cycle count and run limit
	always @(posedge clk_24) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run("timeout, the test did not reach its end within the cycle limit");
		end
	end

	// pixel enable every 4th cycle, vblank for 32 of 400
	always @(negedge clk_24) begin
		ce_6 = (cycles % 4) == 3;
		line_pos = (line_pos == 399) ? 0 : line_pos + 1;
		vblank = line_pos < 32;
	end

	// concurrent checks live in the bound module
	always @(negedge clk_24) begin
		if (UUT.u_sva.failures != 0) begin
			abort_run("a bus or pixel assertion failed");
		end
	end

	task automatic check_byte(input string name, input aznable_pkg::byte_t got,
		input aznable_pkg::byte_t exp);
		assert (got == exp) else begin
			abort_run($sformatf("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp));
		end
	endtask

	// one four-phase transfer, starts and ends on a falling edge
	task automatic bus_cycle(input aznable_pkg::addr_t addr, input logic we,
		input aznable_pkg::byte_t wdata, output aznable_pkg::byte_t rdata);
		int hold;
		bus_addr = addr;
		bus_we = we;
		bus_wdata = wdata;
		bus_req = 1'b1;
		do @(negedge clk_24); while (!bus_ack);
		rdata = bus_rdata;
		// back-pressure before releasing req
		hold = $unsigned($random(seed)) % 4;
		repeat (hold) @(negedge clk_24);
		bus_req = 1'b0;
		do @(negedge clk_24); while (bus_ack);
	endtask

	task automatic bus_read(input aznable_pkg::addr_t addr, output aznable_pkg::byte_t data);
		bus_cycle(addr, 1'b0, 8'h00, data);
	endtask

	task automatic bus_write(input aznable_pkg::addr_t addr, input aznable_pkg::byte_t data);
		aznable_pkg::byte_t unused;
		bus_cycle(addr, 1'b1, data, unused);
	endtask

	function automatic aznable_pkg::addr_t layer_addr(input int layer);
		return {`AZ_REGION_STARS, 5'b00000, layer[1:0], 1'b0};
	endfunction

	// joystick and paddle bytes as the memory map defines them
	function automatic aznable_pkg::byte_t expected_input(input aznable_pkg::addr_t addr);
		aznable_pkg::byte_t exp;
		exp = 8'h00;
		if (addr[15:8] == `AZ_REGION_JOY && addr[4:0] <= 5'd23) begin
			exp = joystick[addr[4:0] * 8 +: 8];
		end else if (addr[15:8] == `AZ_REGION_PADDLE && addr[2:0] <= 3'd5) begin
			exp = paddle[addr[2:0] * 8 +: 8];
		end
		return exp;
	endfunction

	task automatic read_random_inputs(input int count);
		aznable_pkg::addr_t addr;
		aznable_pkg::byte_t got;
		int kind;
		for (int n = 0; n < count; n++) begin
			kind = $unsigned($random(seed)) % 4;
			addr = aznable_pkg::addr_t'($random(seed));
			case (kind)
				0: addr[15:8] = `AZ_REGION_JOY;
				1: addr[15:8] = `AZ_REGION_PADDLE;
				2: addr[15:8] = `AZ_REGION_STARS;
				default: begin
					// keep clear of every mapped region
					if (addr[15:8] inside {`AZ_REGION_JOY, `AZ_REGION_PADDLE,
						`AZ_REGION_TIMER, `AZ_REGION_STARS}) begin
						addr[15:8] = 8'h12;
					end
				end
			endcase
			bus_read(addr, got);
			check_byte("bus_rdata", got, expected_input(addr));
		end
	endtask

	// at least one star must show up in the window
	task automatic watch_stars(input string phase);
		int seen;
		seen = 0;
		repeat (PHASE_CYCLES) begin
			@(negedge clk_24);
			if (pixel_on) begin
				seen++;
			end
		end
		assert (seen > 0) else begin
			abort_run({"no star pixel was seen with ", phase});
		end
	endtask

	initial begin
		aznable_pkg::byte_t got;
		arst_n = 1'b0;
		bus_req = 1'b0;
		bus_we = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		for (int i = 0; i < 6; i++) begin
			joystick[i * 32 +: 32] = $random(seed);
			paddle[i * 8 +: 8] = 8'($random(seed));
		end
		repeat (2) @(negedge clk_24);
		arst_n = 1'b1;

		read_random_inputs(RANDOM_READS);

		// clear, then two milliseconds
		bus_write({`AZ_REGION_TIMER, 8'h00}, 8'h00);
		repeat (2 * `AZ_MS_DIVIDER) @(negedge clk_24);
		bus_read({`AZ_REGION_TIMER, 8'h00}, got);
		assert (got == 8'h01 || got == 8'h02) else begin
			abort_run($sformatf("** Error: ms_count[7:0] = 0x%02h, expected 0x01 or 0x02", got));
		end

		// count is nonzero here, so the clear has to act
		bus_write({`AZ_REGION_TIMER, 8'h00}, 8'h00);
		bus_read({`AZ_REGION_TIMER, 8'h00}, got);
		check_byte("ms_count[7:0]", got, 8'h00);

		// all layers off, select 3 hits nothing
		for (int l = 0; l < 3; l++) begin
			bus_write(layer_addr(l), 8'h00);
		end
		bus_write(layer_addr(3), 8'h01);
		repeat (DARK_CYCLES) @(negedge clk_24);

		bus_write(layer_addr(2), 8'h01);
		watch_stars("only layer 2 enabled");
		bus_write(layer_addr(2), 8'h00);
		bus_write(layer_addr(1), 8'h01);
		watch_stars("only layer 1 enabled");
		bus_write(layer_addr(1), 8'h00);
		repeat (20) @(negedge clk_24);

		if (UUT.u_sva.failures == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			abort_run("a bus or pixel assertion failed");
		end
	end

endmodule

// File: build.f
+incdir+.
aznable_pkg.sv
star_lane_if.sv
bus_decoder.sv
ms_timer.sv
starfield_layer.sv
star_mixer.sv
aznable_io_top.sv
aznable_io_sva.sv
tb_aznable_io.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_aznable_io
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
ERROR_LIMIT ?= 100
PASS_TEXT ?= Test OK

SRCS := $(shell grep -v '^+' $(FILELIST)) aznable_consts.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) +verilator+error+limit+$(ERROR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
